/* Bender.yml */
package:
  name: tx_engine

sources:
  # packages and rtl
  - include_dirs:
      - include
    files:
      - logic/pcie_tlp_pkg.sv
      - logic/tx_stream_pkg.sv
      - logic/tx_out_reg.sv
      - logic/cpl_decode.sv
      - logic/mwr_sequencer.sv
      - logic/tx_engine_top.sv

  # testbench
  - target: simulation
    include_dirs:
      - include
    files:
      - verif/tb_tx_engine.sv

/* filelist.f */
+incdir+include
logic/pcie_tlp_pkg.sv
logic/tx_stream_pkg.sv
logic/tx_out_reg.sv
logic/cpl_decode.sv
logic/mwr_sequencer.sv
logic/tx_engine_top.sv
verif/tb_tx_engine.sv

/* include/tx_engine_params.svh */
`ifndef TX_ENGINE_PARAMS_SVH
`define TX_ENGINE_PARAMS_SVH

// ----------------------------------------------------------------------
// stream geometry
// ----------------------------------------------------------------------

// one beat on either stream
`define TX_DATA_W       256

// keep, one bit per dw
`define TX_KEEP_W       8

`define TX_DW_PER_BEAT  8   // payload dw per write beat

// ----------------------------------------------------------------------
// write path counters
// ----------------------------------------------------------------------

// counted part of the write tag, wraps at 16
`define TX_TAG_W        4

`define TX_PKT_CNT_W    10  // payload packet counter, wraps after 1023

`endif

/* logic/cpl_decode.sv */
`timescale 1ns/100ps
`include "tx_engine_params.svh"

module cpl_decode
        import pcie_tlp_pkg::*;
        import tx_stream_pkg::*;
(
        input  logic     clk,
        input  logic     init_rst_i,

        input  logic     req_valid_i,
        output logic     req_ready_o,
        input  cpl_req_t req_i,

        output logic     beat_valid_o,
        input  logic     beat_ready_i,
        output cc_beat_t beat_o
);

        logic      valid_q;
        cpl_req_t  req_q;       // request under decode
        logic [12:0] byte_cnt;
        logic [1:0]  be_off;    // offset of lowest enabled byte
        cpl_desc_t desc;

        assign req_ready_o  = !valid_q || beat_ready_i;
        assign beat_valid_o = valid_q;

        always_ff @(posedge clk) begin
                if (init_rst_i) begin
                        valid_q <= 1'b0;
                end else if (req_ready_o) begin
                        valid_q <= req_valid_i;
                end
        end

        always_ff @(posedge clk) begin
                if (req_valid_i && req_ready_o) begin
                        req_q <= req_i;
                end
        end

        // ----------------------------------------------------------------------
        // byte count and lower address from the byte enables
        // ----------------------------------------------------------------------
        always_comb begin
                casez (req_q.be)
                        4'b1??1:                   byte_cnt = 13'd4;
                        4'b01?1, 4'b1?10:          byte_cnt = 13'd3;
                        4'b0011, 4'b0110, 4'b1100: byte_cnt = 13'd2;
                        default:                   byte_cnt = 13'd1; // one byte, or none
                endcase
        end

        always_comb begin
                casez (req_q.be)
                        4'b???1: be_off = 2'd0;
                        4'b??10: be_off = 2'd1;
                        4'b?100: be_off = 2'd2;
                        4'b1000: be_off = 2'd3;
                        default: be_off = 2'd0; // no enables
                endcase
        end

        always_comb begin
                desc              = '0;      // success, no completer id, no ecrc
                desc.lower_addr   = {req_q.addr[4:0], be_off};
                desc.byte_count   = byte_cnt;
                desc.dw_count     = {1'b0, req_q.len};
                desc.requester_id = req_q.requester_id;
                desc.tag          = req_q.tag;
                desc.tc           = req_q.tc;
                desc.attr         = {1'b0, req_q.attr};
        end

        // descriptor in dw 0..2, read data in dw 3
        always_comb begin
                beat_o              = '0;
                beat_o.data[95:0]   = desc;
                beat_o.data[127:96] = req_q.rd_data;
                beat_o.keep         = {{(`TX_KEEP_W-4){1'b0}}, 4'hF};
                beat_o.last         = 1'b1;  // single beat completion
        end

        a_beat_hold : assert property (
                @(posedge clk) disable iff (init_rst_i)
                beat_valid_o && !beat_ready_i |=> beat_valid_o && $stable(beat_o)
        );

endmodule

/* logic/mwr_sequencer.sv */
`timescale 1ns/100ps
`include "tx_engine_params.svh"

module mwr_sequencer
        import pcie_tlp_pkg::*;
        import tx_stream_pkg::*;
(
        input  logic     clk,
        input  logic     init_rst_i,

        input  logic     cmd_valid_i,
        output logic     cmd_ready_o,
        input  mwr_cmd_t cmd_i,

        output logic     beat_valid_o,
        input  logic     beat_ready_i,
        output rq_beat_t beat_o
);

        localparam logic [9:0] DW_STEP = 10'(`TX_DW_PER_BEAT);

        typedef enum logic [1:0] {
                ST_IDLE,
                ST_HDR,
                ST_PLD
        } state_t;

        state_t                   state_q;
        mwr_cmd_t                 cmd_q;      // command of the packet in flight
        logic [9:0]               rem_q;      // dw still to send
        logic [`TX_TAG_W-1:0]     tag_cnt_q;
        logic [`TX_PKT_CNT_W-1:0] pkt_cnt_q;  // payload value of this packet
        logic                     beat_xfer;
        logic                     last_beat;
        mwr_desc_t                hdr;

        assign cmd_ready_o  = (state_q == ST_IDLE);
        assign beat_valid_o = (state_q != ST_IDLE);
        assign beat_xfer    = beat_valid_o && beat_ready_i;
        assign last_beat    = (state_q == ST_PLD) && (rem_q == DW_STEP);

        // ----------------------------------------------------------------------
        // packet fsm
        // ----------------------------------------------------------------------
        always_ff @(posedge clk) begin
                if (init_rst_i) begin
                        state_q   <= ST_IDLE;
                        tag_cnt_q <= '0;
                        pkt_cnt_q <= '0;
                end else begin
                        case (state_q)
                        ST_IDLE: begin
                                if (cmd_valid_i) begin
                                        state_q <= ST_HDR;
                                end
                        end
                        ST_HDR: begin
                                if (beat_ready_i) begin
                                        state_q <= ST_PLD;  // header taken
                                end
                        end
                        ST_PLD: begin
                                if (beat_ready_i && last_beat) begin
                                        state_q   <= ST_IDLE;
                                        tag_cnt_q <= tag_cnt_q + 1'b1;  // wraps at 16
                                        pkt_cnt_q <= pkt_cnt_q + 1'b1;  // wraps after 1023
                                end
                        end
                        default: state_q <= ST_IDLE;
                        endcase
                end
        end

        // command capture and dw countdown
        always_ff @(posedge clk) begin
                if (cmd_valid_i && cmd_ready_o) begin
                        cmd_q <= cmd_i;
                        rem_q <= cmd_i.len;
                end else if (beat_xfer && state_q == ST_PLD) begin
                        rem_q <= rem_q - DW_STEP; // one beat worth of dw
                end
        end

        always_comb begin
                hdr          = '0;
                hdr.dw_addr  = cmd_q.dw_addr[29:0];
                hdr.dw_count = {1'b0, cmd_q.len};
                hdr.req_type = REQ_MEM_WRITE;
                hdr.tag      = {{(8-`TX_TAG_W){1'b0}}, tag_cnt_q};
        end

        // header in the low four dw, payload is the packet counter
        always_comb begin
                beat_o          = '0;
                beat_o.keep     = '1;
                beat_o.first_be = cmd_q.first_be;
                beat_o.last_be  = cmd_q.last_be;
                beat_o.last     = last_beat;
                if (state_q == ST_HDR) begin
                        beat_o.data[127:0] = hdr;
                end else begin
                        beat_o.data[`TX_PKT_CNT_W-1:0] = pkt_cnt_q;
                end
        end

        // ----------------------------------------------------------------------
        // checks
        // ----------------------------------------------------------------------
        a_len_ok : assert property (
                @(posedge clk) disable iff (init_rst_i)
                cmd_valid_i && cmd_ready_o |-> cmd_i.len != '0 && cmd_i.len[2:0] == 3'd0
        );

        // no beat is withdrawn once offered
        a_valid_hold : assert property (
                @(posedge clk) disable iff (init_rst_i)
                beat_valid_o && !beat_ready_i |=> beat_valid_o
        );

endmodule

/* logic/pcie_tlp_pkg.sv */
`include "tx_engine_params.svh"

package pcie_tlp_pkg;

        // ----------------------------------------------------------------------
        // read request as handed over by the request decoder
        // ----------------------------------------------------------------------
        typedef struct packed {
                logic [7:0]  tag;
                logic [15:0] requester_id;
                logic [2:0]  tc;
                logic [1:0]  attr;
                logic [9:0]  len;           // length in dw
                logic [3:0]  be;            // first byte enables
                logic [10:0] addr;          // byte address within the bar
                logic [31:0] rd_data;       // one dw of read data
        } cpl_req_t;

        // 3-dw completion descriptor, msb first
        typedef struct packed {
                logic        force_ecrc;    // [95]
                logic [2:0]  attr;
                logic [2:0]  tc;
                logic        cpl_id_en;     // completer id enable
                logic [15:0] completer_id;
                logic [7:0]  tag;
                logic [15:0] requester_id;  // [63:48]
                logic        rsvd3;
                logic        poisoned;
                logic [2:0]  status;        // 0 is successful completion
                logic [10:0] dw_count;      // [42:32]
                logic [1:0]  rsvd2;
                logic        locked;
                logic [12:0] byte_count;    // [28:16]
                logic [5:0]  rsvd1;
                logic [1:0]  addr_type;
                logic        rsvd0;
                logic [6:0]  lower_addr;    // [6:0]
        } cpl_desc_t;

        // 4-dw write request descriptor
        typedef struct packed {
                logic        force_ecrc;    // [127]
                logic [2:0]  attr;
                logic [2:0]  tc;
                logic        req_id_en;
                logic [15:0] completer_id;
                logic [7:0]  tag;           // [103:96]
                logic [15:0] requester_id;
                logic        poisoned;
                logic [3:0]  req_type;
                logic [10:0] dw_count;      // [74:64]
                logic [31:0] addr_hi;       // always zero, 32 bit addressing
                logic [29:0] dw_addr;
                logic [1:0]  addr_type;     // [1:0]
        } mwr_desc_t;

        localparam logic [3:0] REQ_MEM_WRITE = 4'b0001;

endpackage

/* logic/tx_engine_top.sv */
`timescale 1ns/100ps

module tx_engine_top
        import pcie_tlp_pkg::*;
        import tx_stream_pkg::*;
(
        input  logic     clk,
        input  logic     init_rst_i,

        // read requests in, completions out
        input  logic     cpl_req_valid_i,
        output logic     cpl_req_ready_o,
        input  cpl_req_t cpl_req_i,

        // write commands in
        input  logic     mwr_cmd_valid_i,
        output logic     mwr_cmd_ready_o,
        input  mwr_cmd_t mwr_cmd_i,

        output logic     cc_valid_o,
        input  logic     cc_ready_i,
        output cc_beat_t cc_beat_o,

        output logic     rq_valid_o,
        input  logic     rq_ready_i,
        output rq_beat_t rq_beat_o
);

        logic     cpl_beat_valid;
        logic     cpl_beat_ready;
        cc_beat_t cpl_beat;

        logic     mwr_beat_valid;
        logic     mwr_beat_ready;
        rq_beat_t mwr_beat;

        // ----------------------------------------------------------------------
        // completion path
        // ----------------------------------------------------------------------
        cpl_decode cpl_decode_i (
                .clk          (clk),
                .init_rst_i   (init_rst_i),
                .req_valid_i  (cpl_req_valid_i),
                .req_ready_o  (cpl_req_ready_o),
                .req_i        (cpl_req_i),
                .beat_valid_o (cpl_beat_valid),
                .beat_ready_i (cpl_beat_ready),
                .beat_o       (cpl_beat)
        );

        tx_out_reg #(.payload_t(cc_beat_t)) cc_out (
                .clk         (clk),
                .init_rst_i  (init_rst_i),
                .in_valid_i  (cpl_beat_valid),
                .in_ready_o  (cpl_beat_ready),
                .in_i        (cpl_beat),
                .out_valid_o (cc_valid_o),
                .out_ready_i (cc_ready_i),
                .out_o       (cc_beat_o)
        );

        // ----------------------------------------------------------------------
        // requester write path
        // ----------------------------------------------------------------------
        mwr_sequencer mwr_sequencer_i (
                .clk          (clk),
                .init_rst_i   (init_rst_i),
                .cmd_valid_i  (mwr_cmd_valid_i),
                .cmd_ready_o  (mwr_cmd_ready_o),
                .cmd_i        (mwr_cmd_i),
                .beat_valid_o (mwr_beat_valid),
                .beat_ready_i (mwr_beat_ready),
                .beat_o       (mwr_beat)
        );

        tx_out_reg #(.payload_t(rq_beat_t)) rq_out (
                .clk         (clk),
                .init_rst_i  (init_rst_i),
                .in_valid_i  (mwr_beat_valid),
                .in_ready_o  (mwr_beat_ready),
                .in_i        (mwr_beat),
                .out_valid_o (rq_valid_o),
                .out_ready_i (rq_ready_i),
                .out_o       (rq_beat_o)
        );

endmodule

/* logic/tx_out_reg.sv */
`timescale 1ns/100ps

module tx_out_reg #(
        parameter type payload_t = logic
) (
        input  logic     clk,
        input  logic     init_rst_i,

        input  logic     in_valid_i,
        output logic     in_ready_o,
        input  payload_t in_i,

        output logic     out_valid_o,
        input  logic     out_ready_i,
        output payload_t out_o
);

        logic     full_q;   // entry holds a beat
        payload_t data_q;

        // free now, or drained on this same edge
        assign in_ready_o  = !full_q || out_ready_i;
        assign out_valid_o = full_q;
        assign out_o       = data_q;

        always_ff @(posedge clk) begin
                if (init_rst_i) begin
                        full_q <= 1'b0;
                end else if (in_ready_o) begin
                        full_q <= in_valid_i; // refill or go empty
                end
        end

        always_ff @(posedge clk) begin
                if (in_valid_i && in_ready_o) begin
                        data_q <= in_i;
                end
        end

        // ----------------------------------------------------------------------
        // checks
        // ----------------------------------------------------------------------

        // a stalled entry stays put until the sink takes it
        a_out_stable : assert property (
                @(posedge clk) disable iff (init_rst_i)
                out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_o)
        );

endmodule

/* logic/tx_stream_pkg.sv */
`include "tx_engine_params.svh"

package tx_stream_pkg;

        // ----------------------------------------------------------------------
        // beats on the two outgoing streams
        // ----------------------------------------------------------------------

        // completer completion beat
        typedef struct packed {
                logic                  last;
                logic [`TX_KEEP_W-1:0] keep;
                logic [`TX_DATA_W-1:0] data;
        } cc_beat_t;

        typedef struct packed {
                logic [3:0]            last_be;  // sideband byte enables
                logic [3:0]            first_be;
                logic                  last;
                logic [`TX_KEEP_W-1:0] keep;
                logic [`TX_DATA_W-1:0] data;
        } rq_beat_t;

        // write command from the test logic, one per packet
        typedef struct packed {
                logic [21:0] rsvd;      // pads to 72 bit
                logic [31:0] dw_addr;
                logic [9:0]  len;       // dw, nonzero multiple of 8
                logic [3:0]  first_be;
                logic [3:0]  last_be;
        } mwr_cmd_t;

endpackage

/* verif/tb_tx_engine.sv */
`timescale 1ns/100ps
`include "tx_engine_params.svh"

module tb_tx_engine
        import pcie_tlp_pkg::*;
        import tx_stream_pkg::*;
();

        localparam int CLK_PERIOD = 100;
        localparam int N_CPL      = 24;     // requests per completion test
        localparam int N_MWR      = 20;     // commands per write test
        localparam int PKT_BEATS  = 1 + 64 / `TX_DW_PER_BEAT;  // longest packet
        localparam int WD_CYCLES  = 4 * (16 + 2 * N_CPL + 2 * N_MWR * PKT_BEATS);

        logic     clk;
        logic     init_rst_i;
        logic     cpl_req_valid_i;
        logic     cpl_req_ready_o;
        cpl_req_t cpl_req_i;
        logic     mwr_cmd_valid_i;
        logic     mwr_cmd_ready_o;
        mwr_cmd_t mwr_cmd_i;
        logic     cc_valid_o;
        logic     cc_ready_i;
        cc_beat_t cc_beat_o;
        logic     rq_valid_o;
        logic     rq_ready_i;
        rq_beat_t rq_beat_o;

        logic [31:0]              rnd_state = 32'd98610;
        logic [31:0]              rdy_state = 32'd98610;  // own stream for back-pressure
        logic                     cc_stall;   // random back-pressure on/off
        logic                     rq_stall;
        cc_beat_t                 cc_exp_q[$];
        rq_beat_t                 rq_exp_q[$];
        logic [`TX_TAG_W-1:0]     exp_tag;    // next expected write tag
        logic [`TX_PKT_CNT_W-1:0] exp_pkt;    // next expected payload value
        int                       errors;
        int                       checks;
        int                       tests;

        tx_engine_top tx_engine_top_i (.*);

        initial begin
                clk = 1'b0;
                forever #(CLK_PERIOD / 2) clk = ~clk;
        end

        // ----------------------------------------------------------------------
        // helpers
        // ----------------------------------------------------------------------
        function automatic logic [31:0] xorshift32(input logic [31:0] x);
                logic [31:0] s;
                s = x ^ (x << 13);
                s = s ^ (s >> 17);
                s = s ^ (s << 5);
                return s;
        endfunction

        // draws for request and command fields
        function automatic logic [31:0] next_rand();
                rnd_state = xorshift32(rnd_state);
                return rnd_state;
        endfunction

        task automatic report_mismatch(input string sig, input logic [279:0] exp_v,
                                       input logic [279:0] got_v);
                $display("CHECK FAILED at %0t %s expected %h got %h", $time, sig, exp_v, got_v);
                errors++;
        endtask

        // completion beat as the byte-enable rules give it
        function automatic cc_beat_t exp_cpl_beat(input cpl_req_t r);
                cc_beat_t b;
                int       lo;
                int       hi;
                lo = 0;
                hi = 0;
                for (int i = 3; i >= 0; i--) begin
                        if (r.be[i]) lo = i;  // ends on lowest enabled byte
                end
                for (int i = 0; i < 4; i++) begin
                        if (r.be[i]) hi = i;
                end
                b              = '0;
                b.data[6:0]    = {r.addr[4:0], 2'(lo)};
                b.data[28:16]  = (r.be == 4'b0000) ? 13'd1 : 13'(hi - lo + 1);
                b.data[42:32]  = {1'b0, r.len};
                b.data[63:48]  = r.requester_id;
                b.data[71:64]  = r.tag;
                b.data[91:89]  = r.tc;
                b.data[94:92]  = {1'b0, r.attr};
                b.data[127:96] = r.rd_data;  // dw 3
                b.keep         = 8'h0F;
                b.last         = 1'b1;
                return b;
        endfunction

        // header plus len/8 payload beats for one accepted command
        task automatic push_mwr(input mwr_cmd_t c);
                rq_beat_t b;
                int       n;
                b               = '0;
                b.first_be      = c.first_be;
                b.last_be       = c.last_be;
                b.keep          = '1;
                b.data[31:2]    = c.dw_addr[29:0];
                b.data[74:64]   = {1'b0, c.len};
                b.data[78:75]   = 4'd1;         // memory write
                b.data[103:96]  = 8'(exp_tag);
                rq_exp_q.push_back(b);
                n = c.len / `TX_DW_PER_BEAT;
                for (int i = 1; i <= n; i++) begin
                        b.data                    = '0;
                        b.data[`TX_PKT_CNT_W-1:0] = exp_pkt;
                        b.last                    = (i == n);
                        rq_exp_q.push_back(b);
                end
                exp_tag++;  // wraps at 16
                exp_pkt++;
        endtask

        task automatic send_req();
                cpl_req_valid_i <= 1'b1;
                cpl_req_i       <= cpl_req_t'({next_rand(), next_rand(), next_rand()});
                do @(posedge clk); while (!cpl_req_ready_o);
        endtask

        task automatic send_cmd();
                mwr_cmd_t c;
                c          = '0;
                c.dw_addr  = next_rand();
                c.len      = 10'(8 * (1 + next_rand() % 8));  // 8..64 dw
                c.first_be = 4'(next_rand());
                c.last_be  = 4'(next_rand());
                mwr_cmd_valid_i <= 1'b1;
                mwr_cmd_i       <= c;
                do @(posedge clk); while (!mwr_cmd_ready_o);
        endtask

        task automatic end_test(input string name, input int err_before);
                $display("test %-10s done, %0d errors", name, errors - err_before);
                tests++;
        endtask

        // ----------------------------------------------------------------------
        // ready drivers, monitor and assertions
        // ----------------------------------------------------------------------
        always @(posedge clk) begin
                if (cc_stall || rq_stall) begin
                        rdy_state = xorshift32(rdy_state);
                end
                cc_ready_i <= !cc_stall || (rdy_state[1:0] != 2'd0);  // 3 of 4 when stalling
                rq_ready_i <= !rq_stall || (rdy_state[3:2] != 2'd0);
        end

        always @(posedge clk) begin
                if (!init_rst_i) begin
                        if (cpl_req_valid_i && cpl_req_ready_o) begin
                                cc_exp_q.push_back(exp_cpl_beat(cpl_req_i));
                        end
                        if (cc_valid_o && cc_ready_i) begin
                                if (cc_exp_q.size() == 0) begin
                                        $display("completion beat at %0t without a request",
                                                 $time);
                                        errors++;
                                end else begin
                                        checks++;
                                        a_cc_beat : assert (cc_beat_o == cc_exp_q[0])
                                                else report_mismatch("cc_beat_o", cc_exp_q[0],
                                                                     cc_beat_o);
                                        void'(cc_exp_q.pop_front());
                                end
                        end
                        // two or more beats owed means the sequencer still holds one
                        if (rq_exp_q.size() > 1) begin
                                a_cmd_blocked : assert (!mwr_cmd_ready_o)
                                        else report_mismatch("mwr_cmd_ready_o", 0,
                                                             mwr_cmd_ready_o);
                        end
                        if (mwr_cmd_valid_i && mwr_cmd_ready_o) push_mwr(mwr_cmd_i);
                        if (rq_valid_o && rq_ready_i) begin
                                if (rq_exp_q.size() == 0) begin
                                        $display("requester beat at %0t without a command",
                                                 $time);
                                        errors++;
                                end else begin
                                        checks++;
                                        a_rq_beat : assert (rq_beat_o == rq_exp_q[0])
                                                else report_mismatch("rq_beat_o", rq_exp_q[0],
                                                                     rq_beat_o);
                                        void'(rq_exp_q.pop_front());
                                end
                        end
                end
        end

        a_cc_hold : assert property (@(posedge clk) disable iff (init_rst_i)
                cc_valid_o && !cc_ready_i |=> cc_valid_o && $stable(cc_beat_o))
                else begin
                        $display("completion beat changed or dropped while stalled at %0t", $time);
                        errors++;
                end

        a_rq_hold : assert property (@(posedge clk) disable iff (init_rst_i)
                rq_valid_o && !rq_ready_i |=> rq_valid_o && $stable(rq_beat_o))
                else begin
                        $display("requester beat changed or dropped while stalled at %0t", $time);
                        errors++;
                end

        a_cmd_busy : assert property (@(posedge clk) disable iff (init_rst_i)
                mwr_cmd_valid_i && mwr_cmd_ready_o |=> !mwr_cmd_ready_o)
                else begin
                        $display("second write command taken right after one at %0t", $time);
                        errors++;
                end

        initial begin
                repeat (WD_CYCLES) @(posedge clk);
                $display("watchdog expired after %0d cycles, beats stopped arriving", WD_CYCLES);
                $display("Testbench failed");
                $finish;
        end

        // ----------------------------------------------------------------------
        // test sequence
        // ----------------------------------------------------------------------
        initial begin
                int err0;
                init_rst_i      = 1'b1;
                cpl_req_valid_i = 1'b0;
                cpl_req_i       = '0;
                mwr_cmd_valid_i = 1'b0;
                mwr_cmd_i       = '0;
                cc_ready_i      = 1'b1;
                rq_ready_i      = 1'b1;
                cc_stall        = 1'b0;
                rq_stall        = 1'b0;
                exp_tag         = '0;
                exp_pkt         = '0;
                errors          = 0;
                checks          = 0;
                tests           = 0;
                repeat (16) @(posedge clk);
                err0 = errors;
                a_rst_cc : assert (!cc_valid_o) else report_mismatch("cc_valid_o", 0, cc_valid_o);
                a_rst_rq : assert (!rq_valid_o) else report_mismatch("rq_valid_o", 0, rq_valid_o);
                a_rst_crdy : assert (cpl_req_ready_o)
                        else report_mismatch("cpl_req_ready_o", 1, cpl_req_ready_o);
                a_rst_mrdy : assert (mwr_cmd_ready_o)
                        else report_mismatch("mwr_cmd_ready_o", 1, mwr_cmd_ready_o);
                init_rst_i <= 1'b0;
                end_test("reset", err0);

                for (int t = 0; t < 4; t++) begin
                        err0 = errors;
                        cc_stall <= (t == 1);
                        rq_stall <= (t == 3);
                        @(posedge clk);
                        for (int k = 0; k < ((t < 2) ? N_CPL : N_MWR); k++) begin
                                if (t < 2) send_req();
                                else send_cmd();
                        end
                        cpl_req_valid_i <= 1'b0;
                        mwr_cmd_valid_i <= 1'b0;
                        // queues settle on the rising edge, so look between edges
                        while (cc_exp_q.size() != 0 || rq_exp_q.size() != 0) @(negedge clk);
                        @(posedge clk);
                        case (t)
                        0: end_test("cpl_basic", err0);
                        1: end_test("cpl_stall", err0);
                        2: end_test("mwr_basic", err0);
                        default: end_test("mwr_stall", err0);
                        endcase
                end

                $display("%0d tests, %0d beats checked, %0d errors", tests, checks, errors);
                if (errors == 0) begin
                        $display("Testbench passed");
                end else begin
                        $display("Testbench failed");
                end
                $finish;
        end

endmodule
